//--- logic/tcdm_consts.svh
// Cluster-wide counts and widths, included by the packages and every RTL module
`ifndef TCDM_CONSTS_SVH
`define TCDM_CONSTS_SVH

// Cluster shape
`define TCDM_NUM_INI 4
`define TCDM_NUM_BANK 4

// Data path
`define TCDM_DATA_W 32
`define TCDM_BE_W 4

// Initiator byte address and its split
`define TCDM_ADDR_W 16
`define TCDM_BYTE_OFF_W 2
`define TCDM_BANK_ADDR_W 6   // 64 words per bank

// Response queue per bank
`define TCDM_FIFO_DEPTH 2

`endif

//--- logic/tcdm_xbar_pkg.sv
// Interconnect-side types, imported by the crossbar, the interconnect wrapper and the top level
`include "tcdm_consts.svh"

package tcdm_xbar_pkg;

  // Which initiator issued a request
  typedef logic [$clog2(`TCDM_NUM_INI)-1:0] ini_idx_t;

  // Bank selector taken from the address
  typedef logic [$clog2(`TCDM_NUM_BANK)-1:0] bank_idx_t;

  // Full initiator byte address
  typedef logic [`TCDM_ADDR_W-1:0] byte_addr_t;

endpackage : tcdm_xbar_pkg

//--- logic/tcdm_mem_pkg.sv
// Memory-side types for the banks and their response queues, imported where data is handled
`include "tcdm_consts.svh"

package tcdm_mem_pkg;

  typedef logic [`TCDM_DATA_W-1:0] data_t;           // One memory word
  typedef logic [`TCDM_BE_W-1:0] be_t;               // Byte enables, one per byte lane
  typedef logic [`TCDM_BANK_ADDR_W-1:0] bank_addr_t; // Word index inside a bank

  // Bank sequencing
  typedef enum logic [1:0] {
    IDLE,    // Ready for a new request
    WAIT,    // Burning wait states
    RESPOND  // Pushing the response word
  } bank_state_e;

endpackage : tcdm_mem_pkg

//--- logic/tcdm_xbar.sv
// Crossbar with round-robin arbitration per bank and per initiator, wrapped by the interconnect
`include "tcdm_consts.svh"

module tcdm_xbar import tcdm_xbar_pkg::*, tcdm_mem_pkg::*; #(
  parameter int unsigned PayloadW = 1  // Width of the bundled request fields
) (
  input  logic                                      clk_i,
  input  logic                                      rst_n_i,
  // Initiator side
  input  logic      [`TCDM_NUM_INI-1:0]             req_valid_i,
  output logic      [`TCDM_NUM_INI-1:0]             req_ready_o,
  input  bank_idx_t [`TCDM_NUM_INI-1:0]             req_bank_i,     // Target bank
  input  logic      [`TCDM_NUM_INI-1:0][PayloadW-1:0] req_payload_i,
  output logic      [`TCDM_NUM_INI-1:0]             resp_valid_o,
  output data_t     [`TCDM_NUM_INI-1:0]             resp_rdata_o,
  input  logic      [`TCDM_NUM_INI-1:0]             resp_ready_i,
  // Bank side
  output logic      [`TCDM_NUM_BANK-1:0]            req_valid_o,
  output ini_idx_t  [`TCDM_NUM_BANK-1:0]            req_ini_o,      // Winner index
  output logic      [`TCDM_NUM_BANK-1:0][PayloadW-1:0] req_payload_o,
  input  logic      [`TCDM_NUM_BANK-1:0]            req_ready_i,
  input  logic      [`TCDM_NUM_BANK-1:0]            resp_valid_i,
  input  ini_idx_t  [`TCDM_NUM_BANK-1:0]            resp_ini_i,     // Response destination
  input  data_t     [`TCDM_NUM_BANK-1:0]            resp_rdata_i,
  output logic      [`TCDM_NUM_BANK-1:0]            resp_ready_o
);

  // Request arbitration state, one pointer per bank
  ini_idx_t  [`TCDM_NUM_BANK-1:0] req_rr_q;
  logic      [`TCDM_NUM_BANK-1:0] bank_hit;   // Some initiator wants this bank
  ini_idx_t  [`TCDM_NUM_BANK-1:0] bank_win;

  // Response arbitration state, one pointer per initiator
  bank_idx_t [`TCDM_NUM_INI-1:0]  resp_rr_q;
  logic      [`TCDM_NUM_INI-1:0]  ini_hit;
  bank_idx_t [`TCDM_NUM_INI-1:0]  ini_win;

  // Per-bank pick scans down so the one nearest the pointer is kept last
  always_comb begin
    ini_idx_t idx;
    bank_hit = '0;
    bank_win = '0;
    for (int b = 0; b < `TCDM_NUM_BANK; b++) begin
      for (int k = `TCDM_NUM_INI - 1; k >= 0; k--) begin
        idx = ini_idx_t'(req_rr_q[b] + k);  // Wraps at the initiator count
        if (req_valid_i[idx] && req_bank_i[idx] == bank_idx_t'(b)) begin
          bank_hit[b] = 1'b1;
          bank_win[b] = idx;
        end
      end
    end
  end

  // Forward the winner to each bank
  always_comb begin
    for (int b = 0; b < `TCDM_NUM_BANK; b++) begin
      req_valid_o[b]   = bank_hit[b];
      req_ini_o[b]     = bank_win[b];
      req_payload_o[b] = req_payload_i[bank_win[b]];
    end
  end

  // Grant goes back only to the winner, gated by the bank's ready
  always_comb begin
    for (int i = 0; i < `TCDM_NUM_INI; i++) begin
      req_ready_o[i] = bank_hit[req_bank_i[i]] &&
                       bank_win[req_bank_i[i]] == ini_idx_t'(i) &&
                       req_ready_i[req_bank_i[i]];
    end
  end

  // Per-initiator pick among banks holding a response for it
  always_comb begin
    bank_idx_t idx;
    ini_hit = '0;
    ini_win = '0;
    for (int i = 0; i < `TCDM_NUM_INI; i++) begin
      for (int k = `TCDM_NUM_BANK - 1; k >= 0; k--) begin
        idx = bank_idx_t'(resp_rr_q[i] + k);
        if (resp_valid_i[idx] && resp_ini_i[idx] == ini_idx_t'(i)) begin
          ini_hit[i] = 1'b1;
          ini_win[i] = idx;
        end
      end
    end
  end

  always_comb begin
    for (int i = 0; i < `TCDM_NUM_INI; i++) begin
      resp_valid_o[i] = ini_hit[i];
      resp_rdata_o[i] = resp_rdata_i[ini_win[i]];
    end
  end

  // Bank's response leaves only when its initiator picked it and takes it
  always_comb begin
    for (int b = 0; b < `TCDM_NUM_BANK; b++) begin
      resp_ready_o[b] = ini_hit[resp_ini_i[b]] &&
                        ini_win[resp_ini_i[b]] == bank_idx_t'(b) &&
                        resp_ready_i[resp_ini_i[b]];
    end
  end

  // Pointers step past the winner on each transfer
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      req_rr_q  <= '0;
      resp_rr_q <= '0;
    end else begin
      for (int b = 0; b < `TCDM_NUM_BANK; b++) begin
        if (req_valid_o[b] && req_ready_i[b]) req_rr_q[b] <= bank_win[b] + 1'b1;
      end
      for (int i = 0; i < `TCDM_NUM_INI; i++) begin
        if (resp_valid_o[i] && resp_ready_i[i]) resp_rr_q[i] <= ini_win[i] + 1'b1;
      end
    end
  end

endmodule : tcdm_xbar

//--- logic/variable_latency_interconnect.sv
// Address decode and request bundling around the crossbar, instantiated once by the cluster
`include "tcdm_consts.svh"

module variable_latency_interconnect import tcdm_xbar_pkg::*, tcdm_mem_pkg::*; (
  input  logic                                clk_i,
  input  logic                                rst_n_i,
  // Initiator side
  input  logic       [`TCDM_NUM_INI-1:0]      req_valid_i,
  output logic       [`TCDM_NUM_INI-1:0]      req_ready_o,
  input  byte_addr_t [`TCDM_NUM_INI-1:0]      req_addr_i,
  input  logic       [`TCDM_NUM_INI-1:0]      req_wen_i,
  input  data_t      [`TCDM_NUM_INI-1:0]      req_wdata_i,
  input  be_t        [`TCDM_NUM_INI-1:0]      req_be_i,
  output logic       [`TCDM_NUM_INI-1:0]      resp_valid_o,
  input  logic       [`TCDM_NUM_INI-1:0]      resp_ready_i,
  output data_t      [`TCDM_NUM_INI-1:0]      resp_rdata_o,
  // Bank side
  output logic       [`TCDM_NUM_BANK-1:0]     bank_req_valid_o,
  input  logic       [`TCDM_NUM_BANK-1:0]     bank_req_ready_i,
  output ini_idx_t   [`TCDM_NUM_BANK-1:0]     bank_req_ini_o,
  output bank_addr_t [`TCDM_NUM_BANK-1:0]     bank_addr_o,
  output logic       [`TCDM_NUM_BANK-1:0]     bank_wen_o,
  output data_t      [`TCDM_NUM_BANK-1:0]     bank_wdata_o,
  output be_t        [`TCDM_NUM_BANK-1:0]     bank_be_o,
  input  logic       [`TCDM_NUM_BANK-1:0]     bank_resp_valid_i,
  output logic       [`TCDM_NUM_BANK-1:0]     bank_resp_ready_o,
  input  ini_idx_t   [`TCDM_NUM_BANK-1:0]     bank_resp_ini_i,
  input  data_t      [`TCDM_NUM_BANK-1:0]     bank_resp_rdata_i
);

  // wen, be, word address, data
  localparam int unsigned PayloadW = 1 + $bits(be_t) + $bits(bank_addr_t) + $bits(data_t);
  localparam int unsigned BankLsb  = `TCDM_BYTE_OFF_W;                // Bits 3:2
  localparam int unsigned WordLsb  = `TCDM_BYTE_OFF_W + $bits(bank_idx_t); // Bits 9:4

  bank_idx_t [`TCDM_NUM_INI-1:0]                 bank_sel;
  logic      [`TCDM_NUM_INI-1:0][PayloadW-1:0]   payload_ini;
  logic      [`TCDM_NUM_BANK-1:0][PayloadW-1:0]  payload_bank;

  // Byte offset and bits above the word address are dropped, so addresses alias
  for (genvar i = 0; i < `TCDM_NUM_INI; i++) begin : gen_ini
    assign bank_sel[i]    = req_addr_i[i][BankLsb +: $bits(bank_idx_t)];
    assign payload_ini[i] = {req_wen_i[i], req_be_i[i],
                             req_addr_i[i][WordLsb +: $bits(bank_addr_t)], req_wdata_i[i]};
  end

  for (genvar b = 0; b < `TCDM_NUM_BANK; b++) begin : gen_bank
    assign {bank_wen_o[b], bank_be_o[b], bank_addr_o[b], bank_wdata_o[b]} = payload_bank[b];
  end

  tcdm_xbar #(
    .PayloadW (PayloadW)
  ) i_xbar (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .req_valid_i   (req_valid_i),
    .req_ready_o   (req_ready_o),
    .req_bank_i    (bank_sel),
    .req_payload_i (payload_ini),
    .resp_valid_o  (resp_valid_o),
    .resp_rdata_o  (resp_rdata_o),
    .resp_ready_i  (resp_ready_i),
    .req_valid_o   (bank_req_valid_o),
    .req_ini_o     (bank_req_ini_o),
    .req_payload_o (payload_bank),
    .req_ready_i   (bank_req_ready_i),
    .resp_valid_i  (bank_resp_valid_i),
    .resp_ini_i    (bank_resp_ini_i),
    .resp_rdata_i  (bank_resp_rdata_i),
    .resp_ready_o  (bank_resp_ready_o)
  );

endmodule : variable_latency_interconnect

//--- logic/tcdm_bank_resp_fifo.sv
// Per-bank response queue between a bank and the crossbar response side, one per bank in the cluster
`include "tcdm_consts.svh"

module tcdm_bank_resp_fifo import tcdm_xbar_pkg::*, tcdm_mem_pkg::*; #(
  parameter int unsigned Depth = `TCDM_FIFO_DEPTH
) (
  input  logic     clk_i,
  input  logic     rst_n_i,
  // Bank side
  input  logic     push_i,
  input  ini_idx_t push_ini_i,    // Destination initiator
  input  data_t    push_rdata_i,
  output logic     full_o,
  // Crossbar side
  output logic     valid_o,
  output ini_idx_t ini_o,
  output data_t    rdata_o,
  input  logic     ready_i
);

  localparam int unsigned PtrW = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntW = $clog2(Depth + 1);

  ini_idx_t        ini_q   [Depth];
  data_t           rdata_q [Depth];
  logic [PtrW-1:0] wr_ptr_q;
  logic [PtrW-1:0] rd_ptr_q;
  logic [CntW-1:0] count_q;  // Occupancy
  logic            do_push;
  logic            do_pop;

  // Wrap at Depth, which need not be a power of two
  function automatic logic [PtrW-1:0] ptr_inc(input logic [PtrW-1:0] ptr);
    return (ptr == PtrW'(Depth - 1)) ? '0 : ptr + 1'b1;
  endfunction

  assign valid_o = count_q != '0;
  assign full_o  = count_q == CntW'(Depth);
  assign do_pop  = valid_o && ready_i;
  assign do_push = push_i && (!full_o || do_pop);  // Full but draining still takes a push
  assign ini_o   = ini_q[rd_ptr_q];
  assign rdata_o = rdata_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_push) wr_ptr_q <= ptr_inc(wr_ptr_q);
      if (do_pop) rd_ptr_q <= ptr_inc(rd_ptr_q);
      case ({do_push, do_pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;  // Both or neither
      endcase
    end
  end

  // Storage
  always_ff @(posedge clk_i) begin
    if (do_push) begin
      ini_q[wr_ptr_q]   <= push_ini_i;
      rdata_q[wr_ptr_q] <= push_rdata_i;
    end
  end

endmodule : tcdm_bank_resp_fifo

//--- logic/tcdm_bank.sv
// Word-addressed memory bank with byte enables and random wait states, one per bank in the cluster
`include "tcdm_consts.svh"

module tcdm_bank import tcdm_xbar_pkg::*, tcdm_mem_pkg::*; #(
  parameter logic [7:0] LfsrSeed = 8'h1d  // Nonzero, differs per bank
) (
  input  logic       clk_i,
  input  logic       rst_n_i,
  // Request from the crossbar
  input  logic       req_valid_i,
  input  ini_idx_t   req_ini_i,
  input  bank_addr_t req_addr_i,
  input  logic       req_wen_i,
  input  data_t      req_wdata_i,
  input  be_t        req_be_i,
  output logic       req_ready_o,
  // Response queue
  input  logic       fifo_full_i,
  output logic       push_o,
  output ini_idx_t   push_ini_o,
  output data_t      push_rdata_o
);

  localparam int unsigned Words = 1 << `TCDM_BANK_ADDR_W;

  data_t       mem_q [Words];
  bank_state_e state_q;
  logic [1:0]  wait_q;   // Wait states left
  logic [7:0]  lfsr_q;
  logic        lfsr_fb;
  logic        accept;
  ini_idx_t    ini_q;    // Who gets the response
  bank_addr_t  addr_q;

  // One request in flight, and never accept into a full queue
  assign req_ready_o = (state_q == IDLE) && !fifo_full_i;
  assign accept      = req_valid_i && req_ready_o;

  // x^8 + x^6 + x^5 + x^4 + 1
  assign lfsr_fb = lfsr_q[7] ^ lfsr_q[5] ^ lfsr_q[4] ^ lfsr_q[3];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= IDLE;
      wait_q  <= '0;
      lfsr_q  <= LfsrSeed;
    end else begin
      case (state_q)
        IDLE: begin
          if (accept) begin
            wait_q  <= lfsr_q[1:0];                  // 0 to 3 wait states
            lfsr_q  <= {lfsr_q[6:0], lfsr_fb};       // Step once per request
            state_q <= (lfsr_q[1:0] == 2'd0) ? RESPOND : WAIT;
          end
        end
        WAIT: begin
          wait_q <= wait_q - 1'b1;
          if (wait_q == 2'd1) state_q <= RESPOND;    // Last wait state
        end
        RESPOND: state_q <= IDLE;                    // Push happens this cycle
        default: state_q <= IDLE;
      endcase
    end
  end

  // Request fields and byte-enabled write, taken at acceptance
  always_ff @(posedge clk_i) begin
    if (accept) begin
      ini_q  <= req_ini_i;
      addr_q <= req_addr_i;
      if (req_wen_i) begin
        for (int k = 0; k < `TCDM_BE_W; k++) begin
          if (req_be_i[k]) mem_q[req_addr_i][8*k +: 8] <= req_wdata_i[8*k +: 8];
        end
      end
    end
  end

  // Word as stored after any write, so writes echo the merged value
  assign push_o       = state_q == RESPOND;
  assign push_ini_o   = ini_q;
  assign push_rdata_o = mem_q[addr_q];

endmodule : tcdm_bank

//--- logic/tcdm_cluster.sv
// Cluster top level, interconnect plus four banks with response queues, instantiated by the testbench
`include "tcdm_consts.svh"

module tcdm_cluster import tcdm_xbar_pkg::*, tcdm_mem_pkg::*; (
  input  logic                          clk_i,
  input  logic                          rst_n_i,
  input  logic       [`TCDM_NUM_INI-1:0] req_valid_i,
  output logic       [`TCDM_NUM_INI-1:0] req_ready_o,
  input  byte_addr_t [`TCDM_NUM_INI-1:0] req_addr_i,
  input  logic       [`TCDM_NUM_INI-1:0] req_wen_i,
  input  data_t      [`TCDM_NUM_INI-1:0] req_wdata_i,
  input  be_t        [`TCDM_NUM_INI-1:0] req_be_i,
  output logic       [`TCDM_NUM_INI-1:0] resp_valid_o,
  input  logic       [`TCDM_NUM_INI-1:0] resp_ready_i,
  output data_t      [`TCDM_NUM_INI-1:0] resp_rdata_o
);

  // Interconnect to bank
  logic       [`TCDM_NUM_BANK-1:0] bank_req_valid;
  logic       [`TCDM_NUM_BANK-1:0] bank_req_ready;
  ini_idx_t   [`TCDM_NUM_BANK-1:0] bank_req_ini;
  bank_addr_t [`TCDM_NUM_BANK-1:0] bank_addr;
  logic       [`TCDM_NUM_BANK-1:0] bank_wen;
  data_t      [`TCDM_NUM_BANK-1:0] bank_wdata;
  be_t        [`TCDM_NUM_BANK-1:0] bank_be;
  // Bank to queue
  logic       [`TCDM_NUM_BANK-1:0] push;
  ini_idx_t   [`TCDM_NUM_BANK-1:0] push_ini;
  data_t      [`TCDM_NUM_BANK-1:0] push_rdata;
  logic       [`TCDM_NUM_BANK-1:0] fifo_full;
  // Queue to interconnect
  logic       [`TCDM_NUM_BANK-1:0] resp_valid;
  logic       [`TCDM_NUM_BANK-1:0] resp_ready;
  ini_idx_t   [`TCDM_NUM_BANK-1:0] resp_ini;
  data_t      [`TCDM_NUM_BANK-1:0] resp_rdata;

  variable_latency_interconnect i_interconnect (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .req_valid_i       (req_valid_i),
    .req_ready_o       (req_ready_o),
    .req_addr_i        (req_addr_i),
    .req_wen_i         (req_wen_i),
    .req_wdata_i       (req_wdata_i),
    .req_be_i          (req_be_i),
    .resp_valid_o      (resp_valid_o),
    .resp_ready_i      (resp_ready_i),
    .resp_rdata_o      (resp_rdata_o),
    .bank_req_valid_o  (bank_req_valid),
    .bank_req_ready_i  (bank_req_ready),
    .bank_req_ini_o    (bank_req_ini),
    .bank_addr_o       (bank_addr),
    .bank_wen_o        (bank_wen),
    .bank_wdata_o      (bank_wdata),
    .bank_be_o         (bank_be),
    .bank_resp_valid_i (resp_valid),
    .bank_resp_ready_o (resp_ready),
    .bank_resp_ini_i   (resp_ini),
    .bank_resp_rdata_i (resp_rdata)
  );

  for (genvar b = 0; b < `TCDM_NUM_BANK; b++) begin : gen_bank
    tcdm_bank #(
      .LfsrSeed (8'h1d + 8'(b) * 8'h2f)  // Distinct wait patterns per bank
    ) i_bank (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .req_valid_i  (bank_req_valid[b]),
      .req_ini_i    (bank_req_ini[b]),
      .req_addr_i   (bank_addr[b]),
      .req_wen_i    (bank_wen[b]),
      .req_wdata_i  (bank_wdata[b]),
      .req_be_i     (bank_be[b]),
      .req_ready_o  (bank_req_ready[b]),
      .fifo_full_i  (fifo_full[b]),
      .push_o       (push[b]),
      .push_ini_o   (push_ini[b]),
      .push_rdata_o (push_rdata[b])
    );

    tcdm_bank_resp_fifo #(
      .Depth (`TCDM_FIFO_DEPTH)
    ) i_resp_fifo (
      .clk_i        (clk_i),
      .rst_n_i      (rst_n_i),
      .push_i       (push[b]),
      .push_ini_i   (push_ini[b]),
      .push_rdata_i (push_rdata[b]),
      .full_o       (fifo_full[b]),
      .valid_o      (resp_valid[b]),
      .ini_o        (resp_ini[b]),
      .rdata_o      (resp_rdata[b]),
      .ready_i      (resp_ready[b])
    );
  end

endmodule : tcdm_cluster

//--- verif/tcdm_vectors.svh
// Stimulus and expected words for the cluster testbench, included into the testbench module
// Columns of add_row are initiator, write flag, byte address, byte enables, write data, expected, group
// Bits 3:2 of the address pick the bank, bits 9:4 the word, the rest is ignored

localparam int NumGroups = 12;

string group_name [NumGroups];  // Shown in the per-test line

task automatic fill_table();
  group_name[0]  = "full-word writes, one per bank";
  group_name[1]  = "read-back of full words";
  group_name[2]  = "byte-enabled partial writes";
  group_name[3]  = "read-back of merged words";
  group_name[4]  = "writes for routing check";
  group_name[5]  = "reads by another initiator, aliased";
  group_name[6]  = "four writers on one bank";
  group_name[7]  = "four readers on one bank";
  group_name[8]  = "four writers on four banks";
  group_name[9]  = "four readers on four banks";
  group_name[10] = "shared bank under response stalls";
  group_name[11] = "mixed traffic under response stalls";
  // Bank 0..3, word 0
  add_row(0, 1, 16'h0000, 4'hf, 32'h1111_0000, 32'h1111_0000, 0);
  add_row(0, 1, 16'h0004, 4'hf, 32'h2222_0001, 32'h2222_0001, 0);
  add_row(0, 1, 16'h0008, 4'hf, 32'h3333_0002, 32'h3333_0002, 0);
  add_row(0, 1, 16'h000c, 4'hf, 32'h4444_0003, 32'h4444_0003, 0);
  add_row(0, 0, 16'h0000, 4'hf, 32'h0000_0000, 32'h1111_0000, 1);
  add_row(0, 0, 16'h0004, 4'hf, 32'h0000_0000, 32'h2222_0001, 1);
  add_row(0, 0, 16'h0008, 4'hf, 32'h0000_0000, 32'h3333_0002, 1);
  add_row(0, 0, 16'h000c, 4'hf, 32'h0000_0000, 32'h4444_0003, 1);
  // Lane merges, last one with no lanes enabled
  add_row(1, 1, 16'h0000, 4'b0001, 32'hdead_beaa, 32'h1111_00aa, 2);
  add_row(1, 1, 16'h0004, 4'b1100, 32'hcafe_0000, 32'hcafe_0001, 2);
  add_row(1, 1, 16'h0008, 4'b0110, 32'h00be_ef00, 32'h33be_ef02, 2);
  add_row(1, 1, 16'h000c, 4'b0000, 32'hffff_ffff, 32'h4444_0003, 2);
  add_row(1, 0, 16'h0000, 4'hf, 32'h0000_0000, 32'h1111_00aa, 3);
  add_row(1, 0, 16'h0004, 4'hf, 32'h0000_0000, 32'hcafe_0001, 3);
  add_row(1, 0, 16'h0008, 4'hf, 32'h0000_0000, 32'h33be_ef02, 3);
  add_row(1, 0, 16'h000c, 4'hf, 32'h0000_0000, 32'h4444_0003, 3);
  // Word 5 of every bank, plus the top word of bank 0
  add_row(2, 1, 16'h0050, 4'hf, 32'ha0a0_0050, 32'ha0a0_0050, 4);
  add_row(2, 1, 16'h0054, 4'hf, 32'ha0a0_0054, 32'ha0a0_0054, 4);
  add_row(2, 1, 16'h0058, 4'hf, 32'ha0a0_0058, 32'ha0a0_0058, 4);
  add_row(2, 1, 16'h005c, 4'hf, 32'ha0a0_005c, 32'ha0a0_005c, 4);
  add_row(2, 1, 16'h03f0, 4'hf, 32'h5a5a_03f0, 32'h5a5a_03f0, 4);
  add_row(3, 0, 16'h0450, 4'hf, 32'h0000_0000, 32'ha0a0_0050, 5);  // Bit 10 set
  add_row(3, 0, 16'h8054, 4'hf, 32'h0000_0000, 32'ha0a0_0054, 5);
  add_row(3, 0, 16'hf058, 4'hf, 32'h0000_0000, 32'ha0a0_0058, 5);
  add_row(3, 0, 16'h045c, 4'hf, 32'h0000_0000, 32'ha0a0_005c, 5);
  add_row(3, 0, 16'hfff0, 4'hf, 32'h0000_0000, 32'h5a5a_03f0, 5);
  add_row(3, 0, 16'h0053, 4'hf, 32'h0000_0000, 32'ha0a0_0050, 5);  // Byte offset ignored
  // Bank 2, words 16..19
  add_row(0, 1, 16'h0108, 4'hf, 32'h0b0b_0108, 32'h0b0b_0108, 6);
  add_row(1, 1, 16'h0118, 4'hf, 32'h0b0b_0118, 32'h0b0b_0118, 6);
  add_row(2, 1, 16'h0128, 4'hf, 32'h0b0b_0128, 32'h0b0b_0128, 6);
  add_row(3, 1, 16'h0138, 4'hf, 32'h0b0b_0138, 32'h0b0b_0138, 6);
  add_row(0, 0, 16'h0138, 4'hf, 32'h0000_0000, 32'h0b0b_0138, 7);
  add_row(1, 0, 16'h0108, 4'hf, 32'h0000_0000, 32'h0b0b_0108, 7);
  add_row(2, 0, 16'h0118, 4'hf, 32'h0000_0000, 32'h0b0b_0118, 7);
  add_row(3, 0, 16'h0128, 4'hf, 32'h0000_0000, 32'h0b0b_0128, 7);
  // Words 32..35, one bank each
  add_row(0, 1, 16'h0200, 4'hf, 32'hc0de_0200, 32'hc0de_0200, 8);
  add_row(1, 1, 16'h0214, 4'hf, 32'hc0de_0214, 32'hc0de_0214, 8);
  add_row(2, 1, 16'h0228, 4'hf, 32'hc0de_0228, 32'hc0de_0228, 8);
  add_row(3, 1, 16'h023c, 4'hf, 32'hc0de_023c, 32'hc0de_023c, 8);
  add_row(0, 0, 16'h0214, 4'hf, 32'h0000_0000, 32'hc0de_0214, 9);
  add_row(1, 0, 16'h0228, 4'hf, 32'h0000_0000, 32'hc0de_0228, 9);
  add_row(2, 0, 16'h023c, 4'hf, 32'h0000_0000, 32'hc0de_023c, 9);
  add_row(3, 0, 16'h0200, 4'hf, 32'h0000_0000, 32'hc0de_0200, 9);
  // Bank 1, words 48..51, write then read per initiator
  add_row(0, 1, 16'h0304, 4'hf, 32'hf00d_0304, 32'hf00d_0304, 10);
  add_row(0, 0, 16'h0304, 4'hf, 32'h0000_0000, 32'hf00d_0304, 10);
  add_row(1, 1, 16'h0314, 4'hf, 32'hf00d_0314, 32'hf00d_0314, 10);
  add_row(1, 0, 16'h0314, 4'hf, 32'h0000_0000, 32'hf00d_0314, 10);
  add_row(2, 1, 16'h0324, 4'hf, 32'hf00d_0324, 32'hf00d_0324, 10);
  add_row(2, 0, 16'h0324, 4'hf, 32'h0000_0000, 32'hf00d_0324, 10);
  add_row(3, 1, 16'h0334, 4'hf, 32'hf00d_0334, 32'hf00d_0334, 10);
  add_row(3, 0, 16'h0334, 4'hf, 32'h0000_0000, 32'hf00d_0334, 10);
  add_row(0, 1, 16'h0200, 4'b1000, 32'h1100_0000, 32'h11de_0200, 11);
  add_row(0, 0, 16'h0200, 4'hf, 32'h0000_0000, 32'h11de_0200, 11);
  add_row(1, 0, 16'h0000, 4'hf, 32'h0000_0000, 32'h1111_00aa, 11);
  add_row(2, 0, 16'h0004, 4'hf, 32'h0000_0000, 32'hcafe_0001, 11);
  add_row(3, 0, 16'hfff0, 4'hf, 32'h0000_0000, 32'h5a5a_03f0, 11);
endtask

//--- verif/tcdm_cluster_tb.sv
// Table-driven testbench for the cluster, run as top with the file list, prints a summary
`include "tcdm_consts.svh"

module tcdm_cluster_tb import tcdm_xbar_pkg::*, tcdm_mem_pkg::*; ();
  timeunit 1ns;
  timeprecision 100ps;

  localparam int StallGroup = 10;  // From this group on resp_ready_i stalls

  logic                              clk_i;
  logic                              rst_n_i;
  logic       [`TCDM_NUM_INI-1:0]    req_valid_i;
  logic       [`TCDM_NUM_INI-1:0]    req_ready_o;
  byte_addr_t [`TCDM_NUM_INI-1:0]    req_addr_i;
  logic       [`TCDM_NUM_INI-1:0]    req_wen_i;
  data_t      [`TCDM_NUM_INI-1:0]    req_wdata_i;
  be_t        [`TCDM_NUM_INI-1:0]    req_be_i;
  logic       [`TCDM_NUM_INI-1:0]    resp_valid_o;
  logic       [`TCDM_NUM_INI-1:0]    resp_ready_i;
  data_t      [`TCDM_NUM_INI-1:0]    resp_rdata_o;

  `include "tcdm_vectors.svh"

  // Table columns
  int         row_ini   [$];
  logic       row_wen   [$];
  byte_addr_t row_addr  [$];
  be_t        row_be    [$];
  data_t      row_wdata [$];
  data_t      row_exp   [$];
  int         row_group [$];

  integer seed = 32'h449a;
  bit     stall_on;
  int     cycles;
  int     timeout_cycles;   // Zero until the table is loaded
  int     checks;
  int     errors;
  int     tests;

  tcdm_cluster tcdm_cluster_i (.*);

  always #50 clk_i = ~clk_i;

  task automatic add_row(input int ini, input logic wen, input byte_addr_t addr, input be_t be,
                         input data_t wdata, input data_t exp, input int group);
    row_ini.push_back(ini);
    row_wen.push_back(wen);
    row_addr.push_back(addr);
    row_be.push_back(be);
    row_wdata.push_back(wdata);
    row_exp.push_back(exp);
    row_group.push_back(group);
  endtask

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("[ERROR] %0.1f ns: %s, got %h expected %h", $realtime, what, got, exp);
    end
  endtask

  // Random stalls only in the stall groups
  function automatic logic next_ready();
    if (!stall_on) return 1'b1;
    return ($random(seed) % 3) != 0;
  endfunction

  // One request, then its response, from initiator row_ini[r]
  task automatic issue_row(input int r);
    int    i;
    int    others;   // Grants to others on this bank while waiting
    bit    done;
    data_t rdata;
    i = row_ini[r];
    others = 0;
    done = 1'b0;
    @(negedge clk_i);
    req_valid_i[i] = 1'b1;
    req_addr_i[i]  = row_addr[r];
    req_wen_i[i]   = row_wen[r];
    req_be_i[i]    = row_be[r];
    req_wdata_i[i] = row_wdata[r];
    while (!done) begin
      @(posedge clk_i);
      if (req_ready_o[i]) done = 1'b1;
      else begin
        for (int j = 0; j < `TCDM_NUM_INI; j++) begin
          if (j != i && req_valid_i[j] && req_ready_o[j] &&
              req_addr_i[j][3:2] == req_addr_i[i][3:2]) others++;
        end
      end
    end
    compare(others <= 3, 1, $sformatf("row %0d waited past %0d grants", r, others));
    @(negedge clk_i);
    req_valid_i[i]  = 1'b0;
    resp_ready_i[i] = next_ready();
    done = 1'b0;
    while (!done) begin
      @(posedge clk_i);
      if (resp_valid_o[i] && resp_ready_i[i]) begin
        done  = 1'b1;
        rdata = resp_rdata_o[i];
      end else begin
        @(negedge clk_i);
        resp_ready_i[i] = next_ready();
      end
    end
    @(negedge clk_i);
    resp_ready_i[i] = 1'b0;
    compare(rdata, row_exp[r], $sformatf("row %0d ini %0d addr %h", r, i, row_addr[r]));
  endtask

  // Rows of one initiator in a group go out in table order
  task automatic drive_initiator(input int i, input int g);
    for (int r = 0; r < row_ini.size(); r++) begin
      if (row_group[r] == g && row_ini[r] == i) issue_row(r);
    end
  endtask

  task automatic run_group(input int g);
    int err_before;
    err_before = errors;
    stall_on = (g >= StallGroup);
    fork
      drive_initiator(0, g);
      drive_initiator(1, g);
      drive_initiator(2, g);
      drive_initiator(3, g);
    join
    // All answered, so any valid now is a duplicate
    repeat (3) begin
      @(posedge clk_i);
      compare(resp_valid_o, '0, $sformatf("extra response after group %0d", g));
    end
    tests++;
    $display("Test %0d, %s: %s", g, group_name[g], (errors == err_before) ? "ok" : "mismatch");
  endtask

  // Watchdog
  always @(posedge clk_i) begin
    cycles++;
    if (timeout_cycles != 0 && cycles >= timeout_cycles) begin
      $display("Run stopped after %0d cycles, a request or response never completed", cycles);
      $display("TESTBENCH FAILED");
      $finish;
    end
  end

  initial begin
    clk_i        = 1'b0;
    rst_n_i      = 1'b0;
    req_valid_i  = '0;
    req_addr_i   = '0;
    req_wen_i    = '0;
    req_wdata_i  = '0;
    req_be_i     = '0;
    resp_ready_i = '0;
    stall_on     = 1'b0;
    fill_table();
    timeout_cycles = row_ini.size() * 40;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_n_i = 1'b1;
    compare(resp_valid_o, '0, "response valid after reset");
    for (int g = 0; g < NumGroups; g++) run_group(g);
    $display("Summary: %0d tests, %0d checks, %0d errors", tests, checks, errors);
    if (errors == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule : tcdm_cluster_tb

//--- all.f
+incdir+logic
+incdir+verif
logic/tcdm_xbar_pkg.sv
logic/tcdm_mem_pkg.sv
logic/tcdm_xbar.sv
logic/variable_latency_interconnect.sv
logic/tcdm_bank_resp_fifo.sv
logic/tcdm_bank.sv
logic/tcdm_cluster.sv
verif/tcdm_cluster_tb.sv
